/* verilog.f */
common/soc_pkg.sv
hdl/mmu.sv
hdl/onchip_ram.sv
hdl/bus_mux.sv
hdl/irq_encoder.sv
iocontroller/timer_unit.sv
iocontroller/iocontroller.sv
hdl/soc_core.sv
dv/tb_clock.sv
dv/tb_soc_core.sv

/* Bender.yml */
package:
  name: soc_bus_core

sources:
  - common/soc_pkg.sv
  - hdl/mmu.sv
  - hdl/onchip_ram.sv
  - hdl/bus_mux.sv
  - hdl/irq_encoder.sv
  - iocontroller/timer_unit.sv
  - iocontroller/iocontroller.sv
  - hdl/soc_core.sv
  - target: test
    files:
      - dv/tb_clock.sv
      - dv/tb_soc_core.sv

/* dv/tb_soc_core.sv */
`timescale 1ns/1ps

module tb_soc_core;

  localparam int CLK_PERIOD     = 100;
  localparam int ACK_LIMIT      = 8;
  localparam int FAULT_WAIT     = 10;
  localparam int POLL_LIMIT     = 100;
  localparam int BUS_CYCLES     = 5;
  localparam int MEM_ACCESSES   = 2 * 16 + 2 * 17 + 12;
  localparam int IO_ACCESSES    = 16;
  localparam int TIMER_CYCLES   = 5 * 300;
  localparam int KEY_CYCLES     = 100;
  localparam int PLANNED_CYCLES = (MEM_ACCESSES + IO_ACCESSES) * BUS_CYCLES +
                                  3 * (FAULT_WAIT + 3) + TIMER_CYCLES + KEY_CYCLES;
  localparam int MARGIN         = 4;

  logic        sysclock;
  logic        rst_i;
  logic [31:0] cpu_adr_i;
  logic        cpu_cyc_i;
  logic        cpu_we_i;
  logic [3:0]  cpu_sel_i;
  logic [31:0] cpu_dat_i;
  logic        cpu_supervisor_i;
  logic        cpu_int_en_i;
  logic [15:0] sw_i;
  logic        key_i;
  logic [31:0] cpu_dat_o;
  logic        cpu_ack_o;
  logic [3:0]  cpu_interrupt_o;
  logic        mmu_fault_o;
  logic [15:0] led_o;

  int          error_count = 0;
  int          check_count = 0;
  int          last_latency = 0;
  logic [31:0] lcg_state = 32'ha2dc_84e4;

  tb_clock #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clock (
    .sysclock_o (sysclock),
    .rst_o      (rst_i)
  );

  soc_core DUT (
    .sysclock         (sysclock),
    .rst_i            (rst_i),
    .cpu_adr_i        (cpu_adr_i),
    .cpu_cyc_i        (cpu_cyc_i),
    .cpu_we_i         (cpu_we_i),
    .cpu_sel_i        (cpu_sel_i),
    .cpu_dat_i        (cpu_dat_i),
    .cpu_supervisor_i (cpu_supervisor_i),
    .cpu_int_en_i     (cpu_int_en_i),
    .sw_i             (sw_i),
    .key_i            (key_i),
    .cpu_dat_o        (cpu_dat_o),
    .cpu_ack_o        (cpu_ack_o),
    .cpu_interrupt_o  (cpu_interrupt_o),
    .mmu_fault_o      (mmu_fault_o),
    .led_o            (led_o)
  );

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                              input logic [31:0] new_word,
                                              input logic [3:0]  sel);
    logic [31:0] keep;
    keep = {{8{~sel[3]}}, {8{~sel[2]}}, {8{~sel[1]}}, {8{~sel[0]}}};
    return (old_word & keep) | (new_word & ~keep);
  endfunction

  function automatic logic [31:0] io_addr(input logic [3:0] offset);
    return {soc_pkg::REGION_IO, 22'h0, offset, 2'b00};
  endfunction

  function automatic logic [3:0] timer_code(input int n);
    case (n)
      0:       return soc_pkg::EXC_TIMER0;
      1:       return soc_pkg::EXC_TIMER1;
      2:       return soc_pkg::EXC_TIMER2;
      default: return soc_pkg::EXC_TIMER3;
    endcase
  endfunction

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      $display("error: time %0t %s actual %h expected %h", $time, name, actual, expected);
      error_count++;
    end
  endtask

  task automatic step_clock();
    @(posedge sysclock);
    #1;
  endtask

  task automatic bus_start(input logic [31:0] adr, input logic we, input logic [3:0] sel,
                           input logic [31:0] dat, input logic priv);
    step_clock();
    cpu_adr_i        = adr;
    cpu_we_i         = we;
    cpu_sel_i        = sel;
    cpu_dat_i        = dat;
    cpu_supervisor_i = priv;
    cpu_cyc_i        = 1'b1;
  endtask

  // waits for ack, then releases the bus in the following cycle
  task automatic bus_finish(output logic [31:0] rdata);
    bit done;
    done = 1'b0;
    rdata = '0;
    last_latency = 0;
    while (!done && last_latency < ACK_LIMIT) begin
      step_clock();
      last_latency++;
      if (cpu_ack_o) begin
        rdata = cpu_dat_o;
        done = 1'b1;
      end
    end
    if (!done) begin
      $display("bus cycle to %h got no ack within %0d cycles", cpu_adr_i, ACK_LIMIT);
      error_count++;
    end
    step_clock();
    cpu_cyc_i = 1'b0;
    cpu_we_i  = 1'b0;
  endtask

  task automatic bus_write(input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic priv);
    logic [31:0] unused;
    bus_start(adr, 1'b1, sel, dat, priv);
    bus_finish(unused);
  endtask

  task automatic bus_read(input logic [31:0] adr, input logic priv,
                          output logic [31:0] rdata);
    bus_start(adr, 1'b0, 4'hf, 32'h0, priv);
    bus_finish(rdata);
  endtask

  task automatic poll_status(input logic [soc_pkg::NUM_IO_IRQ-1:0] bits, input string name);
    logic [31:0] rdata;
    int          polls;
    polls = 0;
    rdata = '0;
    while ((rdata[soc_pkg::NUM_IO_IRQ-1:0] & bits) != bits && polls < POLL_LIMIT) begin
      bus_read(io_addr(soc_pkg::IO_STATUS), 1'b1, rdata);
      polls++;
    end
    if ((rdata[soc_pkg::NUM_IO_IRQ-1:0] & bits) != bits) begin
      $display("%s status bits %b never set after %0d polls", name, bits, POLL_LIMIT);
      error_count++;
    end
  endtask

  // shadow indexed by the word index wrapped at the memory depth
  task automatic mem_round_trip(input logic [3:0] region, input int depth, input string name);
    logic [31:0] shadow [soc_pkg::RAM_WORDS];
    logic [31:0] adr_list [$];
    logic [31:0] r;
    logic [31:0] adr;
    logic [31:0] data;
    for (int i = 0; i < 16; i++) begin
      r    = next_rand();
      adr  = {region, r[27:2], 2'b00};
      data = next_rand();
      bus_write(adr, data, 4'hf, 1'b1);
      shadow[(adr >> 2) % depth] = data;
      adr_list.push_back(adr);
    end
    foreach (adr_list[i]) begin
      bus_read(adr_list[i], 1'b1, data);
      check({name, " read data"}, data, shadow[(adr_list[i] >> 2) % depth]);
      check({name, " ack latency"}, last_latency, 2);
    end
  endtask

  task automatic test_vect_wrap();
    logic [31:0] adr_hi;
    logic [31:0] adr_lo;
    logic [31:0] data;
    logic [31:0] rdata;
    adr_lo = {soc_pkg::REGION_VECT, 28'h0} + 8 * 4;
    adr_hi = {soc_pkg::REGION_VECT, 28'h0} + (soc_pkg::VECT_WORDS + 8) * 4;
    data   = next_rand();
    bus_write(adr_hi, data, 4'hf, 1'b1);
    bus_read(adr_lo, 1'b1, rdata);
    check("vect wrapped read data", rdata, data);
  endtask

  task automatic test_byte_enables();
    logic [3:0]  sel_list [4];
    logic [31:0] adr;
    logic [31:0] expected;
    logic [31:0] data;
    logic [31:0] rdata;
    sel_list = '{4'b0001, 4'b0100, 4'b1010, 4'b0110};
    adr      = {soc_pkg::REGION_RAM, 28'h0000400};
    expected = next_rand();
    bus_write(adr, expected, 4'hf, 1'b1);
    foreach (sel_list[i]) begin
      data = next_rand();
      bus_write(adr, data, sel_list[i], 1'b1);
      expected = merge_bytes(expected, data, sel_list[i]);
      bus_read(adr, 1'b1, rdata);
      check("byte merged read data", rdata, expected);
    end
  endtask

  // the cycle is held without an ack, then abandoned
  task automatic expect_fault(input logic [31:0] adr, input logic we, input logic priv,
                              input string name);
    int acks;
    acks = 0;
    bus_start(adr, we, 4'hf, 32'h0, priv);
    #1;
    check({name, " mmu_fault_o"}, mmu_fault_o, 1'b1);
    for (int i = 0; i < FAULT_WAIT; i++) begin
      step_clock();
      if (i == 0) begin
        check({name, " cpu_interrupt_o"}, cpu_interrupt_o, soc_pkg::EXC_MMU);
      end
      if (cpu_ack_o) begin
        acks++;
      end
    end
    check({name, " ack count"}, acks, 0);
    cpu_cyc_i = 1'b0;
    cpu_we_i  = 1'b0;
    step_clock();
    check({name, " code after abandon"}, cpu_interrupt_o, soc_pkg::EXC_RESET);
  endtask

  task automatic test_protection();
    logic [31:0] vadr;
    logic [31:0] data;
    logic [31:0] rdata;
    step_clock();
    cpu_int_en_i = 1'b1;
    expect_fault({4'h5, 28'h0000010}, 1'b0, 1'b1, "unmapped read");
    expect_fault(io_addr(soc_pkg::IO_LED), 1'b1, 1'b0, "user io write");
    expect_fault({soc_pkg::REGION_VECT, 28'h0000008}, 1'b1, 1'b0, "user vect write");
    vadr = {soc_pkg::REGION_VECT, 28'h000000c};
    data = next_rand();
    bus_write(vadr, data, 4'hf, 1'b1);
    bus_read(vadr, 1'b0, rdata);
    check("user vect read data", rdata, data);
    cpu_int_en_i = 1'b0;
  endtask

  task automatic test_io_registers();
    logic [31:0] r;
    logic [31:0] rdata;
    r = next_rand();
    step_clock();
    sw_i = r[15:0];
    bus_read(io_addr(soc_pkg::IO_SW), 1'b1, rdata);
    check("io sw read data", rdata, {16'h0, r[15:0]});
    check("io ack latency", last_latency, 1);
    r = next_rand();
    bus_write(io_addr(soc_pkg::IO_LED), r, 4'hf, 1'b1);
    check("led_o", led_o, r[15:0]);
    r = next_rand();
    bus_write(io_addr(soc_pkg::IO_MASK), r, 4'hf, 1'b1);
    bus_read(io_addr(soc_pkg::IO_MASK), 1'b1, rdata);
    check("io mask read data", rdata, r & 32'h1f);
    bus_read(io_addr(4'd12), 1'b1, rdata);
    check("unused offset read data", rdata, 32'h0);
  endtask

  task automatic test_timers();
    logic [31:0] count;
    bus_write(io_addr(soc_pkg::IO_MASK), 32'h1f, 4'hf, 1'b1);
    cpu_int_en_i = 1'b1;
    for (int n = 0; n < soc_pkg::NUM_TIMERS; n++) begin
      bus_read(io_addr(soc_pkg::IO_COUNT), 1'b1, count);
      bus_write(io_addr(4'(soc_pkg::IO_CMP0 + n)), count + 32'd200, 4'hf, 1'b1);
      bus_write(io_addr(soc_pkg::IO_TCTRL), 32'(1 << n), 4'hf, 1'b1);
      poll_status(5'(1 << n), "timer");
      step_clock();
      check("cpu_interrupt_o timer", cpu_interrupt_o, timer_code(n));
      cpu_int_en_i = 1'b0;
      step_clock();
      check("cpu_interrupt_o int_en low", cpu_interrupt_o, soc_pkg::EXC_RESET);
      cpu_int_en_i = 1'b1;
      bus_write(io_addr(soc_pkg::IO_TCTRL), 32'h0, 4'hf, 1'b1);
      bus_write(io_addr(soc_pkg::IO_STATUS), 32'(1 << n), 4'hf, 1'b1);
      step_clock();
      check("cpu_interrupt_o timer cleared", cpu_interrupt_o, soc_pkg::EXC_RESET);
    end
    // timer0 and timer2 pending together
    bus_read(io_addr(soc_pkg::IO_COUNT), 1'b1, count);
    bus_write(io_addr(soc_pkg::IO_CMP0), count + 32'd150, 4'hf, 1'b1);
    bus_write(io_addr(soc_pkg::IO_CMP2), count + 32'd200, 4'hf, 1'b1);
    bus_write(io_addr(soc_pkg::IO_TCTRL), 32'h5, 4'hf, 1'b1);
    poll_status(5'b00101, "timer pair");
    step_clock();
    check("cpu_interrupt_o timer pair", cpu_interrupt_o, soc_pkg::EXC_TIMER2);
    bus_write(io_addr(soc_pkg::IO_STATUS), 32'h4, 4'hf, 1'b1);
    step_clock();
    check("cpu_interrupt_o timer0 left", cpu_interrupt_o, soc_pkg::EXC_TIMER0);
    bus_write(io_addr(soc_pkg::IO_STATUS), 32'h1, 4'hf, 1'b1);
    bus_write(io_addr(soc_pkg::IO_TCTRL), 32'h0, 4'hf, 1'b1);
    step_clock();
    check("cpu_interrupt_o pair cleared", cpu_interrupt_o, soc_pkg::EXC_RESET);
  endtask

  task automatic test_key();
    logic [31:0] rdata;
    step_clock();
    key_i = 1'b0;
    poll_status(5'(1 << soc_pkg::IRQ_KEY), "key");
    step_clock();
    check("cpu_interrupt_o key", cpu_interrupt_o, soc_pkg::EXC_KEY);
    bus_write(io_addr(soc_pkg::IO_STATUS), 32'(1 << soc_pkg::IRQ_KEY), 4'hf, 1'b1);
    repeat (10) step_clock();
    bus_read(io_addr(soc_pkg::IO_STATUS), 1'b1, rdata);
    check("key status held low", rdata & 32'(1 << soc_pkg::IRQ_KEY), 32'h0);
    step_clock();
    check("cpu_interrupt_o key cleared", cpu_interrupt_o, soc_pkg::EXC_RESET);
    key_i = 1'b1;
  endtask

  initial begin
    cpu_adr_i        = '0;
    cpu_cyc_i        = 1'b0;
    cpu_we_i         = 1'b0;
    cpu_sel_i        = '0;
    cpu_dat_i        = '0;
    cpu_supervisor_i = 1'b1;
    cpu_int_en_i     = 1'b0;
    sw_i             = '0;
    key_i            = 1'b1;
    wait (rst_i == 1'b0);
    mem_round_trip(soc_pkg::REGION_RAM, soc_pkg::RAM_WORDS, "ram");
    mem_round_trip(soc_pkg::REGION_VECT, soc_pkg::VECT_WORDS, "vect");
    test_vect_wrap();
    test_byte_enables();
    test_protection();
    test_io_registers();
    test_timers();
    test_key();
    step_clock();
    $display("checks run %0d, errors %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    #(PLANNED_CYCLES * MARGIN * CLK_PERIOD);
    $display("timeout, the run did not finish within %0d cycles", PLANNED_CYCLES * MARGIN);
    $display("Checks failed");
    $finish;
  end

endmodule

/* dv/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic sysclock_o,
  output logic rst_o
);

  initial begin
    sysclock_o = 1'b0;
    forever begin
      #(PERIOD / 2) sysclock_o = ~sysclock_o;
    end
  end

  // released just after a rising edge
  initial begin
    rst_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge sysclock_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

/* hdl/soc_core.sv */
`timescale 1ns/1ps

module soc_core (
  input  logic        sysclock,
  input  logic        rst_i,
  input  logic [31:0] cpu_adr_i,
  input  logic        cpu_cyc_i,
  input  logic        cpu_we_i,
  input  logic [3:0]  cpu_sel_i,
  input  logic [31:0] cpu_dat_i,
  input  logic        cpu_supervisor_i,
  input  logic        cpu_int_en_i,
  input  logic [15:0] sw_i,
  input  logic        key_i,
  output logic [31:0] cpu_dat_o,
  output logic        cpu_ack_o,
  output logic [3:0]  cpu_interrupt_o,
  output logic        mmu_fault_o,
  output logic [15:0] led_o
);

  logic                          ram_stb;
  logic                          vect_stb;
  logic                          io_stb;
  logic [31:0]                   ram_dat;
  logic [31:0]                   vect_dat;
  logic [31:0]                   io_dat;
  logic                          ram_ack;
  logic                          vect_ack;
  logic                          io_ack;
  logic [soc_pkg::NUM_IO_IRQ-1:0] io_irq;

  mmu u_mmu (
    .adr_i        (cpu_adr_i),
    .cyc_i        (cpu_cyc_i),
    .we_i         (cpu_we_i),
    .supervisor_i (cpu_supervisor_i),
    .ram_stb_o    (ram_stb),
    .vect_stb_o   (vect_stb),
    .io_stb_o     (io_stb),
    .fault_o      (mmu_fault_o)
  );

  onchip_ram #(.DEPTH(soc_pkg::RAM_WORDS)) u_ram (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .stb_i    (ram_stb),
    .we_i     (cpu_we_i),
    .sel_i    (cpu_sel_i),
    .adr_i    (cpu_adr_i),
    .dat_i    (cpu_dat_i),
    .dat_o    (ram_dat),
    .ack_o    (ram_ack)
  );

  onchip_ram #(.DEPTH(soc_pkg::VECT_WORDS)) u_vect (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .stb_i    (vect_stb),
    .we_i     (cpu_we_i),
    .sel_i    (cpu_sel_i),
    .adr_i    (cpu_adr_i),
    .dat_i    (cpu_dat_i),
    .dat_o    (vect_dat),
    .ack_o    (vect_ack)
  );

  iocontroller u_io (
    .sysclock (sysclock),
    .rst_i    (rst_i),
    .stb_i    (io_stb),
    .we_i     (cpu_we_i),
    .sel_i    (cpu_sel_i),
    .adr_i    (cpu_adr_i),
    .dat_i    (cpu_dat_i),
    .sw_i     (sw_i),
    .key_i    (key_i),
    .dat_o    (io_dat),
    .ack_o    (io_ack),
    .led_o    (led_o),
    .irq_o    (io_irq)
  );

  bus_mux u_mux (
    .ram_stb_i  (ram_stb),
    .vect_stb_i (vect_stb),
    .io_stb_i   (io_stb),
    .ram_dat_i  (ram_dat),
    .vect_dat_i (vect_dat),
    .io_dat_i   (io_dat),
    .ram_ack_i  (ram_ack),
    .vect_ack_i (vect_ack),
    .io_ack_i   (io_ack),
    .dat_o      (cpu_dat_o),
    .ack_o      (cpu_ack_o)
  );

  irq_encoder u_irq (
    .sysclock    (sysclock),
    .rst_i       (rst_i),
    .int_en_i    (cpu_int_en_i),
    .fault_i     (mmu_fault_o),
    .io_irq_i    (io_irq),
    .interrupt_o (cpu_interrupt_o)
  );

endmodule

/* iocontroller/iocontroller.sv */
`timescale 1ns/1ps

module iocontroller (
  input  logic                          sysclock,
  input  logic                          rst_i,
  input  logic                          stb_i,
  input  logic                          we_i,
  input  logic [3:0]                    sel_i,
  input  logic [31:0]                   adr_i,
  input  logic [31:0]                   dat_i,
  input  logic [15:0]                   sw_i,
  input  logic                          key_i,
  output logic [31:0]                   dat_o,
  output logic                          ack_o,
  output logic [15:0]                   led_o,
  output logic [soc_pkg::NUM_IO_IRQ-1:0] irq_o
);

  logic [3:0]                    offset;
  logic                          access;
  logic                          wr;
  logic [31:0]                   wmask;
  logic [31:0]                   rd_data;
  logic [soc_pkg::NUM_IO_IRQ-1:0] status;
  logic [soc_pkg::NUM_IO_IRQ-1:0] mask;
  logic [soc_pkg::NUM_IO_IRQ-1:0] irq_set;
  logic [soc_pkg::NUM_IO_IRQ-1:0] irq_clr;
  logic [soc_pkg::NUM_TIMERS-1:0] timer_en;
  logic [soc_pkg::NUM_TIMERS-1:0] cmp_wr;
  logic [soc_pkg::NUM_TIMERS-1:0] timer_hit;
  logic [31:0]                   count;
  logic [1:0]                    key_sync;
  logic                          key_prev;
  logic                          key_fall;

  assign offset = adr_i[5:2];
  assign access = stb_i & ~ack_o;
  assign wr     = access & we_i;
  assign wmask  = {{8{sel_i[3]}}, {8{sel_i[2]}}, {8{sel_i[1]}}, {8{sel_i[0]}}};

  // one-edge ack, the cycle after it is ignored
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // key is active low, idles high
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      key_sync <= 2'b11;
      key_prev <= 1'b1;
    end else begin
      key_sync <= {key_sync[0], key_i};
      key_prev <= key_sync[1];
    end
  end

  assign key_fall = key_prev & ~key_sync[1];
  assign irq_set  = {key_fall, timer_hit};
  assign irq_clr  = (wr && offset == soc_pkg::IO_STATUS) ?
                    dat_i[soc_pkg::NUM_IO_IRQ-1:0] & wmask[soc_pkg::NUM_IO_IRQ-1:0] : '0;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      led_o    <= '0;
      mask     <= '0;
      status   <= '0;
      timer_en <= '0;
    end else begin
      // a new event wins over a clear in the same cycle
      status <= (status & ~irq_clr) | irq_set;
      if (wr && offset == soc_pkg::IO_LED) begin
        led_o <= (led_o & ~wmask[15:0]) | (dat_i[15:0] & wmask[15:0]);
      end
      if (wr && offset == soc_pkg::IO_MASK) begin
        mask <= (mask & ~wmask[soc_pkg::NUM_IO_IRQ-1:0]) |
                (dat_i[soc_pkg::NUM_IO_IRQ-1:0] & wmask[soc_pkg::NUM_IO_IRQ-1:0]);
      end
      if (wr && offset == soc_pkg::IO_TCTRL) begin
        timer_en <= (timer_en & ~wmask[soc_pkg::NUM_TIMERS-1:0]) |
                    (dat_i[soc_pkg::NUM_TIMERS-1:0] & wmask[soc_pkg::NUM_TIMERS-1:0]);
      end
    end
  end

  always_comb begin
    cmp_wr = '0;
    cmp_wr[0] = wr && offset == soc_pkg::IO_CMP0;
    cmp_wr[1] = wr && offset == soc_pkg::IO_CMP1;
    cmp_wr[2] = wr && offset == soc_pkg::IO_CMP2;
    cmp_wr[3] = wr && offset == soc_pkg::IO_CMP3;
  end

  // compare registers are write only and read as zero
  always_comb begin
    rd_data = '0;
    case (offset)
      soc_pkg::IO_SW:     rd_data[15:0] = sw_i;
      soc_pkg::IO_LED:    rd_data[15:0] = led_o;
      soc_pkg::IO_STATUS: rd_data[soc_pkg::NUM_IO_IRQ-1:0] = status;
      soc_pkg::IO_MASK:   rd_data[soc_pkg::NUM_IO_IRQ-1:0] = mask;
      soc_pkg::IO_COUNT:  rd_data = count;
      soc_pkg::IO_TCTRL:  rd_data[soc_pkg::NUM_TIMERS-1:0] = timer_en;
      default:            rd_data = '0;
    endcase
  end

  always_ff @(posedge sysclock) begin
    if (access) begin
      dat_o <= rd_data;
    end
  end

  assign irq_o = status & mask;

  timer_unit u_timer (
    .sysclock  (sysclock),
    .rst_i     (rst_i),
    .en_i      (timer_en),
    .cmp_wr_i  (cmp_wr),
    .cmp_dat_i (dat_i),
    .count_o   (count),
    .hit_o     (timer_hit)
  );

endmodule

/* iocontroller/timer_unit.sv */
`timescale 1ns/1ps

module timer_unit (
  input  logic                          sysclock,
  input  logic                          rst_i,
  input  logic [soc_pkg::NUM_TIMERS-1:0] en_i,
  input  logic [soc_pkg::NUM_TIMERS-1:0] cmp_wr_i,
  input  logic [31:0]                   cmp_dat_i,
  output logic [31:0]                   count_o,
  output logic [soc_pkg::NUM_TIMERS-1:0] hit_o
);

  logic [31:0]                   cmp [soc_pkg::NUM_TIMERS];
  logic [soc_pkg::NUM_TIMERS-1:0] match;

  // free running, wraps at 2^32
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      count_o <= '0;
    end else begin
      count_o <= count_o + 32'd1;
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      for (int n = 0; n < soc_pkg::NUM_TIMERS; n++) begin
        cmp[n] <= '0;
      end
    end else begin
      for (int n = 0; n < soc_pkg::NUM_TIMERS; n++) begin
        if (cmp_wr_i[n]) begin
          cmp[n] <= cmp_dat_i;
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < soc_pkg::NUM_TIMERS; n++) begin
      match[n] = en_i[n] && (cmp[n] == count_o);
    end
  end

  // counter moves every cycle so a match is only ever one cycle wide
  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      hit_o <= '0;
    end else begin
      hit_o <= match;
    end
  end

endmodule

/* hdl/irq_encoder.sv */
`timescale 1ns/1ps

module irq_encoder (
  input  logic                          sysclock,
  input  logic                          rst_i,
  input  logic                          int_en_i,
  input  logic                          fault_i,
  input  logic [soc_pkg::NUM_IO_IRQ-1:0] io_irq_i,
  output logic [3:0]                    interrupt_o
);

  logic [3:0] code;

  always_comb begin
    code = soc_pkg::EXC_RESET;
    if (int_en_i) begin
      if (fault_i) begin
        code = soc_pkg::EXC_MMU;
      end else if (io_irq_i[3]) begin
        code = soc_pkg::EXC_TIMER3;
      end else if (io_irq_i[2]) begin
        code = soc_pkg::EXC_TIMER2;
      end else if (io_irq_i[1]) begin
        code = soc_pkg::EXC_TIMER1;
      end else if (io_irq_i[0]) begin
        code = soc_pkg::EXC_TIMER0;
      end else if (io_irq_i[soc_pkg::IRQ_KEY]) begin
        code = soc_pkg::EXC_KEY;
      end
    end
  end

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      interrupt_o <= soc_pkg::EXC_RESET;
    end else begin
      interrupt_o <= code;
    end
  end

endmodule

/* hdl/bus_mux.sv */
`timescale 1ns/1ps

module bus_mux (
  input  logic        ram_stb_i,
  input  logic        vect_stb_i,
  input  logic        io_stb_i,
  input  logic [31:0] ram_dat_i,
  input  logic [31:0] vect_dat_i,
  input  logic [31:0] io_dat_i,
  input  logic        ram_ack_i,
  input  logic        vect_ack_i,
  input  logic        io_ack_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);

  // and-or select, strobes are one-hot or all low
  assign dat_o = ({32{ram_stb_i}}  & ram_dat_i)  |
                 ({32{vect_stb_i}} & vect_dat_i) |
                 ({32{io_stb_i}}   & io_dat_i);

  assign ack_o = (ram_stb_i  & ram_ack_i)  |
                 (vect_stb_i & vect_ack_i) |
                 (io_stb_i   & io_ack_i);

endmodule

/* hdl/onchip_ram.sv */
`timescale 1ns/1ps

module onchip_ram #(
  parameter int DEPTH = soc_pkg::RAM_WORDS
) (
  input  logic        sysclock,
  input  logic        rst_i,
  input  logic        stb_i,
  input  logic        we_i,
  input  logic [3:0]  sel_i,
  input  logic [31:0] adr_i,
  input  logic [31:0] dat_i,
  output logic [31:0] dat_o,
  output logic        ack_o
);

  localparam int AW = $clog2(DEPTH);

  logic [31:0]   mem [DEPTH];
  logic [AW-1:0] idx;
  logic          ack_p1;
  logic          start;

  // word index, upper address bits wrap
  assign idx = adr_i[AW+1:2];

  // new request only when neither pipeline stage is busy
  assign start = stb_i & ~ack_p1 & ~ack_o;

  always_ff @(posedge sysclock or posedge rst_i) begin
    if (rst_i) begin
      ack_p1 <= 1'b0;
      ack_o  <= 1'b0;
    end else begin
      ack_p1 <= start;
      ack_o  <= ack_p1;
    end
  end

  always_ff @(posedge sysclock) begin
    if (start && we_i) begin
      for (int b = 0; b < 4; b++) begin
        if (sel_i[b]) begin
          mem[idx][8*b +: 8] <= dat_i[8*b +: 8];
        end
      end
    end
  end

  // read port follows the held address, settled by the ack cycle
  always_ff @(posedge sysclock) begin
    dat_o <= mem[idx];
  end

endmodule

/* hdl/mmu.sv */
`timescale 1ns/1ps

module mmu (
  input  logic [31:0] adr_i,
  input  logic        cyc_i,
  input  logic        we_i,
  input  logic        supervisor_i,
  output logic        ram_stb_o,
  output logic        vect_stb_o,
  output logic        io_stb_o,
  output logic        fault_o
);

  logic [3:0] region;
  logic       ram_hit;
  logic       io_hit;
  logic       vect_hit;
  logic       unmapped;
  logic       user_violation;

  assign region   = adr_i[31:28];
  assign ram_hit  = (region == soc_pkg::REGION_RAM);
  assign io_hit   = (region == soc_pkg::REGION_IO);
  assign vect_hit = (region == soc_pkg::REGION_VECT);
  assign unmapped = ~(ram_hit | io_hit | vect_hit);

  // user mode may read vectors but not write them, and has no io access
  assign user_violation = ~supervisor_i & (io_hit | (vect_hit & we_i));

  assign fault_o = cyc_i & (unmapped | user_violation);

  // a faulting cycle gets no strobe, so it never sees an ack
  assign ram_stb_o  = cyc_i & ram_hit & ~fault_o;
  assign vect_stb_o = cyc_i & vect_hit & ~fault_o;
  assign io_stb_o   = cyc_i & io_hit & ~fault_o;

endmodule

/* common/soc_pkg.sv */
package soc_pkg;

  // address regions, decoded from adr[31:28]
  localparam logic [3:0] REGION_RAM  = 4'h0;
  localparam logic [3:0] REGION_IO   = 4'h2;
  localparam logic [3:0] REGION_VECT = 4'hf;

  // memory depths in 32-bit words
  localparam int RAM_WORDS  = 1024;
  localparam int VECT_WORDS = 32;

  // exception codes presented to the cpu
  localparam logic [3:0] EXC_RESET  = 4'd0;
  localparam logic [3:0] EXC_MMU    = 4'd1;
  localparam logic [3:0] EXC_TIMER3 = 4'd2;
  localparam logic [3:0] EXC_TIMER2 = 4'd3;
  localparam logic [3:0] EXC_TIMER1 = 4'd4;
  localparam logic [3:0] EXC_TIMER0 = 4'd5;
  localparam logic [3:0] EXC_KEY    = 4'd6;

  // io interrupt sources, timers in bits 0..3 and the key in bit 4
  localparam int NUM_IO_IRQ = 5;
  localparam int NUM_TIMERS = 4;
  localparam int IRQ_KEY    = 4;

  // io register word offsets, from adr[5:2]
  localparam logic [3:0] IO_SW     = 4'd0;
  localparam logic [3:0] IO_LED    = 4'd1;
  localparam logic [3:0] IO_STATUS = 4'd2;
  localparam logic [3:0] IO_MASK   = 4'd3;
  localparam logic [3:0] IO_COUNT  = 4'd4;
  localparam logic [3:0] IO_TCTRL  = 4'd5;
  localparam logic [3:0] IO_CMP0   = 4'd6;
  localparam logic [3:0] IO_CMP1   = 4'd7;
  localparam logic [3:0] IO_CMP2   = 4'd8;
  localparam logic [3:0] IO_CMP3   = 4'd9;

endpackage
